/* Makefile */
TOP = pixel_ser_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* design/lane_extractor.sv */
`timescale 1ns/1ps

module lane_extractor (
  input  logic                      m_clk_if,
  input  logic                      reset,
  input  pixel_ser_pkg::lane_sel_t  lane_sel,
  input  pixel_ser_pkg::fifo_word_u fifo_word,
  output pixel_ser_pkg::pixel_out_t pixel
);

  import pixel_ser_pkg::*;

  logic [PIXEL_W-1:0] lane_val;
  logic               valid_q;
  logic [PIXEL_W-1:0] data_q;

  // ----------------------------------------
  // lane select
  // ----------------------------------------
  always_comb
  begin
    lane_val = '0;
    case (lane_sel.mode)
      bpp_1:
      begin
        lane_val = PIXEL_W'(fifo_word.b1[lane_sel.lane]);
      end
      bpp_2:
      begin
        lane_val = PIXEL_W'(fifo_word.b2[lane_sel.lane[3:0]]);
      end
      bpp_4:
      begin
        lane_val = PIXEL_W'(fifo_word.b4[lane_sel.lane[2:0]]);
      end
      bpp_8:
      begin
        lane_val = PIXEL_W'(fifo_word.b8[lane_sel.lane[1:0]]);
      end
      // 565 and 444 packing is resolved further down the pipe
      bpp_16, bpp_16_565, bpp_16_444:
      begin
        lane_val = PIXEL_W'(fifo_word.b16[lane_sel.lane[0]]);
      end
      bpp_24:
      begin
        lane_val = fifo_word.b24.pix;
      end
      default:
      begin
        lane_val = '0;
      end
    endcase
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge m_clk_if)
  begin
    if (reset)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= lane_sel.fire;
    end
  end

  // data holds between pixels
  always_ff @(posedge m_clk_if)
  begin
    if (lane_sel.fire)
    begin
      data_q <= lane_val;
    end
  end

  assign pixel.valid = valid_q;
  assign pixel.data  = data_q;

  // 24 bpp never fires past its single lane
  a_lane_24: assert property (
    @(posedge m_clk_if) disable iff (reset)
    (lane_sel.fire && lane_sel.mode == bpp_24) |-> (lane_sel.lane == '0)
  ) else $error("24 bpp fired on lane %0d", lane_sel.lane);

endmodule

/* design/lane_sequencer.sv */
`timescale 1ns/1ps

module lane_sequencer (
  input  logic                     m_clk_if,
  input  logic                     reset,
  input  pixel_ser_pkg::bpp_mode_t bpp_mode,
  input  logic                     fifo_empty,
  input  logic                     stop,
  input  logic                     v_sync,
  output logic                     fifo_rd,
  output pixel_ser_pkg::lane_sel_t lane_sel
);

  import pixel_ser_pkg::*;

  lane_idx_t  lane_q;
  logic [5:0] lane_cnt;
  logic       fire;
  logic       last_lane;

  // ----------------------------------------
  // fire and end-of-word decode
  // ----------------------------------------
  assign lane_cnt = lanes_per_word(bpp_mode);

  // stop and an empty FIFO hold the current lane
  assign fire = !fifo_empty && !stop && !v_sync;

  assign last_lane = ({1'b0, lane_q} == (lane_cnt - 6'd1));

  // pop together with the last pixel of the word
  assign fifo_rd = fire && last_lane;

  always_comb
  begin
    lane_sel.fire = fire;
    lane_sel.mode = bpp_mode;
    lane_sel.lane = lane_q;
  end

  // ----------------------------------------
  // lane counter
  // ----------------------------------------
  always_ff @(posedge m_clk_if)
  begin
    if (reset)
    begin
      lane_q <= '0;
    end
    else if (v_sync)
    begin
      // frame sync restarts the word at its first pixel
      lane_q <= '0;
    end
    else if (fire)
    begin
      if (last_lane)
      begin
        lane_q <= '0;
      end
      else
      begin
        lane_q <= lane_q + 5'd1;
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // catches a mode change in the middle of a word
  a_lane_in_range: assert property (
    @(posedge m_clk_if) disable iff (reset)
    {1'b0, lane_q} < lane_cnt
  ) else $error("lane %0d out of range for mode %s", lane_q, bpp_mode.name());

endmodule

/* design/pixel_ser_pkg.sv */
package pixel_ser_pkg;

  // ----------------------------------------
  // word and pixel format
  // ----------------------------------------
  localparam int WORD_W  = 32;
  localparam int PIXEL_W = 24;

  // colour depth codes in LCD control register encoding
  typedef enum logic [2:0] {
    bpp_1      = 3'b000,
    bpp_2      = 3'b001,
    bpp_4      = 3'b010,
    bpp_8      = 3'b011,
    bpp_16     = 3'b100,
    bpp_24     = 3'b101,
    bpp_16_565 = 3'b110,
    bpp_16_444 = 3'b111
  } bpp_mode_t;

  // 24 bpp pixel sits in the low bits
  typedef struct packed {
    logic [WORD_W-PIXEL_W-1:0] pad;
    logic [PIXEL_W-1:0]        pix;
  } word_24_t;

  // one FIFO word, seen at every lane width
  typedef union packed {
    logic [WORD_W-1:0]         b1;
    logic [WORD_W/2-1:0][1:0]  b2;
    logic [WORD_W/4-1:0][3:0]  b4;
    logic [WORD_W/8-1:0][7:0]  b8;
    logic [WORD_W/16-1:0][15:0] b16;
    word_24_t                  b24;
    logic [WORD_W-1:0]         raw;
  } fifo_word_u;

  typedef logic [4:0] lane_idx_t;

  // sequencer to extractor
  typedef struct packed {
    logic      fire;
    bpp_mode_t mode;
    lane_idx_t lane;
  } lane_sel_t;

  typedef struct packed {
    logic               valid;
    logic [PIXEL_W-1:0] data;
  } pixel_out_t;

  // ----------------------------------------
  // pixels per word for a mode
  // ----------------------------------------
  function automatic logic [5:0] lanes_per_word(bpp_mode_t mode);
    logic [5:0] cnt;
    case (mode)
      bpp_1:      cnt = 6'd32;
      bpp_2:      cnt = 6'd16;
      bpp_4:      cnt = 6'd8;
      bpp_8:      cnt = 6'd4;
      bpp_16:     cnt = 6'd2;
      bpp_24:     cnt = 6'd1;
      bpp_16_565: cnt = 6'd2;
      bpp_16_444: cnt = 6'd2;
      default:    cnt = 6'd1;
    endcase
    return cnt;
  endfunction

endpackage

/* design/pixel_ser_top.sv */
`timescale 1ns/1ps

module pixel_ser_top (
  input  logic                      m_clk_if,
  input  logic                      reset,
  input  pixel_ser_pkg::bpp_mode_t  bpp_mode,
  input  pixel_ser_pkg::fifo_word_u fifo_word,
  input  logic                      fifo_empty,
  input  logic                      stop,
  input  logic                      v_sync,
  output logic                      fifo_rd,
  output pixel_ser_pkg::pixel_out_t pixel
);

  import pixel_ser_pkg::*;

  // lane choice for the pixel firing this cycle
  lane_sel_t lane_sel;

  // ----------------------------------------
  // lane counter and FIFO pop
  // ----------------------------------------
  lane_sequencer u_lane_sequencer (
    .m_clk_if   (m_clk_if),
    .reset      (reset),
    .bpp_mode   (bpp_mode),
    .fifo_empty (fifo_empty),
    .stop       (stop),
    .v_sync     (v_sync),
    .fifo_rd    (fifo_rd),
    .lane_sel   (lane_sel)
  );

  // ----------------------------------------
  // pixel pick and output register
  // ----------------------------------------
  // show-ahead FIFO head word goes straight in
  lane_extractor u_lane_extractor (
    .m_clk_if  (m_clk_if),
    .reset     (reset),
    .lane_sel  (lane_sel),
    .fifo_word (fifo_word),
    .pixel     (pixel)
  );

endmodule

/* dv/pixel_ser_model.svh */
`ifndef PIXEL_SER_MODEL_SVH
`define PIXEL_SER_MODEL_SVH

// pixels carried by one FIFO word
function automatic int ref_pixels_per_word(input bpp_mode_t mode);
  case (mode)
    bpp_1:   return 32;
    bpp_2:   return 16;
    bpp_4:   return 8;
    bpp_8:   return 4;
    bpp_24:  return 1;
    // plain, 565 and 444 all carry two halves
    default: return 2;
  endcase
endfunction

// pixel at a lane, counted from the low end of the word
function automatic logic [23:0] ref_pixel(input logic [31:0] word, input bpp_mode_t mode,
                                          input int lane);
  int          width;
  logic [31:0] mask;
  logic [31:0] shifted;
  if (mode == bpp_24)
    return word[23:0];
  width   = 32 / ref_pixels_per_word(mode);
  mask    = (32'h1 << width) - 32'h1;
  shifted = word >> (lane * width);
  return 24'(shifted & mask);
endfunction

`endif

/* dv/pixel_ser_tb.sv */
`timescale 1ns/1ps

module pixel_ser_tb;

  import pixel_ser_pkg::*;

  `include "pixel_ser_model.svh"

  localparam int CLK_PERIOD  = 8;
  localparam int TOTAL_WORDS = 8 + 32 + 2 + 6 + 12 + 3;
  localparam int TIMEOUT_NS  = TOTAL_WORDS * 40 * CLK_PERIOD + 2000;

  logic       m_clk_if;
  logic       reset;
  bpp_mode_t  bpp_mode;
  fifo_word_u fifo_word;
  logic       fifo_empty;
  logic       stop;
  logic       v_sync;
  logic       fifo_rd;
  pixel_out_t pixel;

  int          seed = 32'h2f1816af;
  logic [31:0] fifo_q[$];
  logic [23:0] exp_data[$];
  int          exp_due[$];
  int          cyc = 0;
  int          trk_lane = 0;
  bit          rd_seen = 1'b0;
  int          pop_count = 0;
  int          pix_count = 0;
  int          err_count = 0;
  int          test_err = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  pixel_ser_top uut (
    .m_clk_if   (m_clk_if),
    .reset      (reset),
    .bpp_mode   (bpp_mode),
    .fifo_word  (fifo_word),
    .fifo_empty (fifo_empty),
    .stop       (stop),
    .v_sync     (v_sync),
    .fifo_rd    (fifo_rd),
    .pixel      (pixel)
  );

  initial m_clk_if = 1'b0;
  always #(CLK_PERIOD / 2) m_clk_if = ~m_clk_if;

  always @(posedge m_clk_if)
    cyc <= cyc + 1;

  task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
      err_count++;
      test_err++;
    end
  endtask

  function automatic bit chance(input int pct);
    return ((($random(seed)) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  // ----------------------------------------
  // FIFO model and stimulus
  // ----------------------------------------
  always @(negedge m_clk_if)
  begin
    if (reset)
      rd_seen = 1'b0;
    else
    begin
      rd_seen = fifo_rd;
      if (fifo_rd)
        pop_count++;
    end
  end

  task automatic step(input int stop_pct, input int gap_pct, input bit vs);
    bit gap;
    @(posedge m_clk_if);
    #1;
    if (rd_seen)
    begin
      if (fifo_q.size() == 0)
      begin
        $display("ERROR at %0t: fifo_rd seen while the FIFO held no word", $time);
        err_count++;
        test_err++;
      end
      else
        void'(fifo_q.pop_front());
    end
    gap    = chance(gap_pct);
    stop   = chance(stop_pct);
    v_sync = vs;
    if (fifo_q.size() == 0 || gap)
    begin
      // junk on the bus while empty
      fifo_empty    = 1'b1;
      fifo_word.raw = $random(seed);
    end
    else
    begin
      fifo_empty    = 1'b0;
      fifo_word.raw = fifo_q[0];
    end
  endtask

  // ----------------------------------------
  // prediction and comparison
  // ----------------------------------------
  always @(negedge m_clk_if)
  begin
    bit exp_rd;
    exp_rd = 1'b0;
    if (reset)
      trk_lane = 0;
    else
    begin
      if (v_sync)
        trk_lane = 0;
      else if (!fifo_empty && !stop)
      begin
        exp_data.push_back(ref_pixel(fifo_q[0], bpp_mode, trk_lane));
        exp_due.push_back(cyc + 1);
        if (trk_lane == ref_pixels_per_word(bpp_mode) - 1)
        begin
          exp_rd   = 1'b1;
          trk_lane = 0;
        end
        else
          trk_lane++;
      end
      check_val(32'(fifo_rd), 32'(exp_rd), "fifo_rd");
    end
  end

  always @(negedge m_clk_if)
  begin
    if (!reset)
    begin
      if (pixel.valid)
      begin
        pix_count++;
        if (exp_due.size() == 0 || exp_due[0] != cyc)
        begin
          $display("ERROR at %0t: a pixel came out with no expected pixel pending", $time);
          err_count++;
          test_err++;
        end
        else
        begin
          check_val(32'(pixel.data), 32'(exp_data[0]), "pixel data");
          void'(exp_data.pop_front());
          void'(exp_due.pop_front());
        end
      end
      else if (exp_due.size() != 0 && exp_due[0] == cyc)
      begin
        $display("ERROR at %0t: an expected pixel did not come out", $time);
        err_count++;
        test_err++;
        void'(exp_data.pop_front());
        void'(exp_due.pop_front());
      end
    end
  end

  // words in, run until drained, then check the totals
  task automatic run_test(input string name, input bpp_mode_t mode, input int nwords,
                          input int stop_pct, input int gap_pct, input int vs_at,
                          input int extra);
    int start_pix;
    int start_pop;
    int n;
    test_err  = 0;
    start_pix = pix_count;
    start_pop = pop_count;
    bpp_mode  = mode;
    for (int i = 0; i < nwords; i++)
      fifo_q.push_back($random(seed));
    n = 0;
    while (fifo_q.size() != 0 || exp_due.size() != 0)
    begin
      step(stop_pct, gap_pct, n == vs_at);
      n++;
    end
    check_val(pix_count - start_pix, nwords * ref_pixels_per_word(mode) + extra, "pixel count");
    check_val(pop_count - start_pop, nwords, "pop count");
    tests_run++;
    if (test_err != 0)
      tests_failed++;
    $display("test %s: %0d pixels, %0d pops, %0d errors", name, pix_count - start_pix,
             pop_count - start_pop, test_err);
  endtask

  initial
  begin
    bpp_mode_t mode_m;
    bpp_mode      = bpp_8;
    fifo_word.raw = '0;
    fifo_empty    = 1'b1;
    stop          = 1'b0;
    v_sync        = 1'b0;
    reset         = 1'b1;
    repeat (4) @(posedge m_clk_if);
    #1;
    reset = 1'b0;

    run_test("8 bpp stream", bpp_8, 8, 0, 0, -1, 0);
    for (int m = 0; m < 8; m++)
    begin
      mode_m = bpp_mode_t'(m);
      run_test({"mode ", mode_m.name()}, mode_m, 4, 0, 0, -1, 0);
    end
    run_test("stop 1 bpp", bpp_1, 2, 30, 0, -1, 0);
    run_test("stop 4 bpp", bpp_4, 6, 30, 0, -1, 0);
    run_test("empty gaps", bpp_8, 12, 0, 35, -1, 0);
    // sync lands on lane 5 of the first word
    run_test("v_sync restart", bpp_2, 3, 0, 0, 5, 5);

    if (exp_due.size() != 0)
    begin
      $display("ERROR: %0d expected pixels never came out", exp_due.size());
      err_count++;
    end
    $display("summary: %0d tests, %0d failed, %0d errors, %0d pixels", tests_run,
             tests_failed, err_count, pix_count);
    if (err_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* project.f */
design/pixel_ser_pkg.sv
design/lane_sequencer.sv
design/lane_extractor.sv
design/pixel_ser_top.sv
+incdir+dv
dv/pixel_ser_tb.sv
